/* lane_pkg.sv */
`default_nettype none

package lane_pkg;

   ////////////////////////////////////////////////////
   // link-side word format
   ////////////////////////////////////////////////////

   // rotation logic in the buffer only supports four lanes
   localparam int NUM_LANES = 4;
   localparam int WORD_WIDTH = 64;
   localparam int EOP_WIDTH = 4;

   typedef logic [WORD_WIDTH-1:0] word_t;
   typedef logic [EOP_WIDTH-1:0] eop_code_t;

   // 0 to 4 words
   typedef logic [2:0] num_valid_t;

   // stored word is {sop, eop code, data}
   localparam int EXT_WORD_WIDTH = 1 + EOP_WIDTH + WORD_WIDTH;
   typedef logic [EXT_WORD_WIDTH-1:0] ext_word_t;

   localparam int SOP_POS = EXT_WORD_WIDTH - 1;
   localparam int EOP_LSB = WORD_WIDTH;

   // bit 3 set is a normal end with byte count in 2..0
   localparam eop_code_t EOP_ERROR = 4'b0001;

   function automatic logic is_end(eop_code_t code);
      return code[3] || (code == EOP_ERROR);
   endfunction

endpackage

`default_nettype wire

/* stream_pkg.sv */
`default_nettype none

package stream_pkg;

   localparam int BYTES_PER_WORD = 8;

   // beat width follows the link lane count
   localparam int BEAT_WORDS = lane_pkg::NUM_LANES;

   // 0 to 31 unused bytes in a beat
   typedef logic [4:0] empty_t;

   // unused bytes of a beat holding n_words words
   // tail_bytes is the byte count of the last word, 0 means all eight
   function automatic empty_t beat_empty(lane_pkg::num_valid_t n_words,
                                         logic [2:0] tail_bytes);
      int tail_missing;
      tail_missing = (tail_bytes == 3'd0) ? 0 : BYTES_PER_WORD - int'(tail_bytes);
      return empty_t'((BEAT_WORDS - int'(n_words)) * BYTES_PER_WORD + tail_missing);
   endfunction

endpackage

`default_nettype wire

/* word_ram_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface word_ram_if #(
   parameter int ADDR_WIDTH = 6
) ();

   ////////////////////////////////////////////////////
   // write side, all four lanes from wr_addr upward
   ////////////////////////////////////////////////////

   logic [ADDR_WIDTH-1:0] wr_addr;
   lane_pkg::ext_word_t [lane_pkg::NUM_LANES-1:0] wr_data;

   ////////////////////////////////////////////////////
   // read side, word at rd_addr returns in lane 0
   ////////////////////////////////////////////////////

   logic [ADDR_WIDTH-1:0] rd_addr;
   lane_pkg::ext_word_t [lane_pkg::NUM_LANES-1:0] rd_data;

   modport writer (output wr_addr, output wr_data);

   modport reader (output rd_addr, input rd_data);

   modport ram (input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface

`default_nettype wire

/* word_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module word_writer #(
   parameter int ADDR_WIDTH = 6
) (
   input  logic clk,
   input  logic arst,
   input  lane_pkg::num_valid_t in_num_valid,
   input  logic [lane_pkg::NUM_LANES-1:0] in_sop,
   input  lane_pkg::eop_code_t [lane_pkg::NUM_LANES-1:0] in_eop,
   input  lane_pkg::word_t [lane_pkg::NUM_LANES-1:0] in_data,
   output lane_pkg::num_valid_t wr_num_valid,
   output lane_pkg::num_valid_t wr_eop_ofs,
   word_ram_if.writer ram
);

   logic [ADDR_WIDTH-1:0] wr_addr;
   lane_pkg::num_valid_t eop_ofs;

   ////////////////////////////////////////////////////
   // write pointer and registered write info
   ////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         wr_addr <= '0;
         wr_num_valid <= '0;
         wr_eop_ofs <= '0;
      end else begin
         wr_addr <= wr_addr + ADDR_WIDTH'(in_num_valid);
         wr_num_valid <= in_num_valid;
         wr_eop_ofs <= eop_ofs;
      end
   end

   assign ram.wr_addr = wr_addr;

   // sop and eop code ride above the data
   always_comb begin
      for (int i = 0; i < lane_pkg::NUM_LANES; i++) begin
         ram.wr_data[i] = {in_sop[i], in_eop[i], in_data[i]};
      end
   end

   ////////////////////////////////////////////////////
   // eop offset, 1 for lane 0 up to 4 for lane 3
   ////////////////////////////////////////////////////

   // only one end per cycle since packets span four words or more
   always_comb begin
      eop_ofs = '0;
      for (int i = 0; i < lane_pkg::NUM_LANES; i++) begin
         if (i < int'(in_num_valid) && lane_pkg::is_end(in_eop[i])) begin
            eop_ofs = lane_pkg::num_valid_t'(i + 1);
         end
      end
   end

   a_num_valid_range: assert property (@(posedge clk) disable iff (arst)
      in_num_valid <= lane_pkg::num_valid_t'(lane_pkg::NUM_LANES));

endmodule

`default_nettype wire

/* read_scheduler.sv */
`timescale 1ns/100ps
`default_nettype none

module read_scheduler #(
   parameter int ADDR_WIDTH = 6,
   parameter int EOP_DEPTH = 8
) (
   input  logic clk,
   input  logic arst,
   input  lane_pkg::num_valid_t wr_num_valid,
   input  lane_pkg::num_valid_t wr_eop_ofs,
   output lane_pkg::num_valid_t rd_num_valid,
   output logic overflow
);

   // extra bit tells a full buffer from an empty one
   typedef logic [ADDR_WIDTH:0] ptr_t;

   // eop depth is a power of two so the queue indices wrap by themselves
   localparam int QW = $clog2(EOP_DEPTH);
   typedef logic [QW-1:0] qidx_t;
   typedef logic [QW:0] qcnt_t;

   localparam int BUF_WORDS = 2 ** ADDR_WIDTH;
   localparam ptr_t LANES = ptr_t'(lane_pkg::NUM_LANES);

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   ptr_t stored;
   ptr_t eop_dist;

   ptr_t eop_q [EOP_DEPTH];
   qidx_t eop_head;
   qidx_t eop_tail;
   qcnt_t eop_count;
   logic eop_push;
   logic eop_pop;
   logic eop_full;

   lane_pkg::num_valid_t grant;

   ////////////////////////////////////////////////////
   // word pointers
   ////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         rd_num_valid <= '0;
      end else begin
         wr_ptr <= wr_ptr + ptr_t'(wr_num_valid);
         rd_ptr <= rd_ptr + ptr_t'(grant);
         rd_num_valid <= grant;
      end
   end

   assign stored = wr_ptr - rd_ptr;

   ////////////////////////////////////////////////////
   // pending eop addresses
   ////////////////////////////////////////////////////

   assign eop_push = (wr_eop_ofs != '0);
   assign eop_full = (eop_count == qcnt_t'(EOP_DEPTH));

   // absolute word address of the end
   always_ff @(posedge clk) begin
      if (eop_push) begin
         eop_q[eop_tail] <= wr_ptr + ptr_t'(wr_eop_ofs) - ptr_t'(1);
      end
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         eop_head <= '0;
         eop_tail <= '0;
         eop_count <= '0;
      end else begin
         if (eop_push) begin
            eop_tail <= eop_tail + qidx_t'(1);
         end
         if (eop_pop) begin
            eop_head <= eop_head + qidx_t'(1);
         end
         if (eop_push && !eop_pop) begin
            eop_count <= eop_count + qcnt_t'(1);
         end else if (!eop_push && eop_pop) begin
            eop_count <= eop_count - qcnt_t'(1);
         end
      end
   end

   ////////////////////////////////////////////////////
   // read rule
   ////////////////////////////////////////////////////

   assign eop_dist = eop_q[eop_head] - rd_ptr + ptr_t'(1);

   // stop at a near end, else take a full beat when one is stored
   always_comb begin
      grant = '0;
      eop_pop = 1'b0;
      if (eop_count != '0 && eop_dist <= LANES) begin
         grant = lane_pkg::num_valid_t'(eop_dist);
         eop_pop = 1'b1;
      end else if (stored >= LANES) begin
         grant = lane_pkg::num_valid_t'(lane_pkg::NUM_LANES);
      end
   end

   // keep eight words of headroom for the all-lane writes
   assign overflow = (stored > ptr_t'(BUF_WORDS - 8)) || eop_full;

   a_grant_stored: assert property (@(posedge clk) disable iff (arst)
      ptr_t'(grant) <= stored);

   a_eop_push_full: assert property (@(posedge clk) disable iff (arst)
      eop_full |-> !eop_push);

endmodule

`default_nettype wire

/* word_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module word_ram #(
   parameter int ADDR_WIDTH = 6
) (
   input logic clk,
   word_ram_if.ram ram
);

   localparam int LANES = lane_pkg::NUM_LANES;
   localparam int ROW_WIDTH = ADDR_WIDTH - 2;

   typedef logic [ADDR_WIDTH-1:0] addr_t;

   lane_pkg::ext_word_t bank_q [LANES];
   logic [1:0] rd_rot;

   ////////////////////////////////////////////////////
   // banks, word address low bits pick the bank
   ////////////////////////////////////////////////////

   for (genvar b = 0; b < LANES; b++) begin : g_bank
      lane_pkg::ext_word_t mem [2 ** ROW_WIDTH];
      logic [1:0] wr_lane;
      logic [1:0] rd_lane;
      addr_t wr_word;
      addr_t rd_word;

      // input lane that lands in this bank
      assign wr_lane = 2'(b) - ram.wr_addr[1:0];
      assign wr_word = ram.wr_addr + addr_t'(wr_lane);

      // word this bank contributes to the read beat
      assign rd_lane = 2'(b) - ram.rd_addr[1:0];
      assign rd_word = ram.rd_addr + addr_t'(rd_lane);

      always_ff @(posedge clk) begin
         mem[wr_word[ADDR_WIDTH-1:2]] <= ram.wr_data[wr_lane];
         bank_q[b] <= mem[rd_word[ADDR_WIDTH-1:2]];
      end
   end

   always_ff @(posedge clk) begin
      rd_rot <= ram.rd_addr[1:0];
   end

   ////////////////////////////////////////////////////
   // rotate back so rd_addr sits in lane 0
   ////////////////////////////////////////////////////

   always_comb begin
      logic [1:0] sel;
      for (int l = 0; l < LANES; l++) begin
         sel = 2'(l) + rd_rot;
         ram.rd_data[l] = bank_q[sel];
      end
   end

endmodule

`default_nettype wire

/* out_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module out_framer #(
   parameter int ADDR_WIDTH = 6
) (
   input  logic clk,
   input  logic arst,
   input  lane_pkg::num_valid_t rd_num_valid,
   word_ram_if.reader ram,
   output lane_pkg::word_t [lane_pkg::NUM_LANES-1:0] out_data,
   output logic out_valid,
   output logic out_sop,
   output logic out_eop,
   output logic out_error,
   output stream_pkg::empty_t out_empty
);

   localparam int LANES = lane_pkg::NUM_LANES;

   logic [ADDR_WIDTH-1:0] rd_addr;

   // grant count lined up with the ram read data
   lane_pkg::num_valid_t beat_words;

   logic beat_valid;
   logic [1:0] last_lane;
   lane_pkg::eop_code_t last_code;
   logic [LANES-1:0] lane_sop;
   logic [LANES-1:0] lane_used;
   logic beat_eop;
   logic beat_error;
   stream_pkg::empty_t beat_empty;

   ////////////////////////////////////////////////////
   // read address and grant delay
   ////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         rd_addr <= '0;
         beat_words <= '0;
      end else begin
         rd_addr <= rd_addr + ADDR_WIDTH'(rd_num_valid);
         beat_words <= rd_num_valid;
      end
   end

   assign ram.rd_addr = rd_addr;
   assign beat_valid = (beat_words != '0);

   ////////////////////////////////////////////////////
   // decode of the last word in the beat
   ////////////////////////////////////////////////////

   assign last_lane = 2'(beat_words - lane_pkg::num_valid_t'(1));
   assign last_code = ram.rd_data[last_lane][lane_pkg::EOP_LSB +: lane_pkg::EOP_WIDTH];

   always_comb begin
      for (int l = 0; l < LANES; l++) begin
         lane_sop[l] = ram.rd_data[l][lane_pkg::SOP_POS];
         lane_used[l] = (l < int'(beat_words));
      end
   end

   always_comb begin
      beat_eop = 1'b0;
      beat_error = 1'b0;
      beat_empty = stream_pkg::beat_empty(beat_words, 3'd0);
      if (last_code[3]) begin
         beat_eop = 1'b1;
         beat_empty = stream_pkg::beat_empty(beat_words, last_code[2:0]);
      end else if (last_code == lane_pkg::EOP_ERROR) begin
         // errored packet reports a full beat
         beat_eop = 1'b1;
         beat_error = 1'b1;
         beat_empty = '0;
      end
   end

   ////////////////////////////////////////////////////
   // output register
   ////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         out_valid <= 1'b0;
         out_sop <= 1'b0;
         out_eop <= 1'b0;
         out_error <= 1'b0;
         out_empty <= '0;
      end else begin
         out_valid <= beat_valid;
         out_sop <= beat_valid && lane_sop[0];
         out_eop <= beat_valid && beat_eop;
         out_error <= beat_valid && beat_error;
         out_empty <= beat_valid ? beat_empty : '0;
      end
   end

   always_ff @(posedge clk) begin
      for (int l = 0; l < LANES; l++) begin
         out_data[l] <= ram.rd_data[l][lane_pkg::WORD_WIDTH-1:0];
      end
   end

   // scheduler cuts beats at packet ends so a start is only ever in lane 0
   a_sop_lane0: assert property (@(posedge clk) disable iff (arst)
      beat_valid |-> (lane_sop[LANES-1:1] & lane_used[LANES-1:1]) == '0);

endmodule

`default_nettype wire

/* regroup_top.sv */
`timescale 1ns/100ps
`default_nettype none

module regroup_top #(
   parameter int ADDR_WIDTH = 6,
   parameter int EOP_DEPTH = 8
) (
   input  logic clk,
   input  logic arst,
   input  lane_pkg::num_valid_t in_num_valid,
   input  logic [lane_pkg::NUM_LANES-1:0] in_sop,
   input  lane_pkg::eop_code_t [lane_pkg::NUM_LANES-1:0] in_eop,
   input  lane_pkg::word_t [lane_pkg::NUM_LANES-1:0] in_data,
   output lane_pkg::word_t [lane_pkg::NUM_LANES-1:0] out_data,
   output logic out_valid,
   output logic out_sop,
   output logic out_eop,
   output stream_pkg::empty_t out_empty,
   output logic out_error,
   output logic overflow
);

   lane_pkg::num_valid_t wr_num_valid;
   lane_pkg::num_valid_t wr_eop_ofs;
   lane_pkg::num_valid_t rd_num_valid;

   word_ram_if #(.ADDR_WIDTH(ADDR_WIDTH)) ram_bus ();

   ////////////////////////////////////////////////////
   // write side
   ////////////////////////////////////////////////////

   word_writer #(.ADDR_WIDTH(ADDR_WIDTH)) u_writer (
      .clk          (clk),
      .arst         (arst),
      .in_num_valid (in_num_valid),
      .in_sop       (in_sop),
      .in_eop       (in_eop),
      .in_data      (in_data),
      .wr_num_valid (wr_num_valid),
      .wr_eop_ofs   (wr_eop_ofs),
      .ram          (ram_bus.writer)
   );

   read_scheduler #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .EOP_DEPTH  (EOP_DEPTH)
   ) u_sched (
      .clk          (clk),
      .arst         (arst),
      .wr_num_valid (wr_num_valid),
      .wr_eop_ofs   (wr_eop_ofs),
      .rd_num_valid (rd_num_valid),
      .overflow     (overflow)
   );

   ////////////////////////////////////////////////////
   // storage and read side
   ////////////////////////////////////////////////////

   word_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
      .clk (clk),
      .ram (ram_bus.ram)
   );

   out_framer #(.ADDR_WIDTH(ADDR_WIDTH)) u_framer (
      .clk          (clk),
      .arst         (arst),
      .rd_num_valid (rd_num_valid),
      .ram          (ram_bus.reader),
      .out_data     (out_data),
      .out_valid    (out_valid),
      .out_sop      (out_sop),
      .out_eop      (out_eop),
      .out_error    (out_error),
      .out_empty    (out_empty)
   );

endmodule

`default_nettype wire

/* tb_regroup.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_regroup;

   localparam int LANES = lane_pkg::NUM_LANES;

   // one link word as the generator hands it out
   typedef struct packed {
      logic sop;
      lane_pkg::eop_code_t eop;
      lane_pkg::word_t data;
   } lane_word_t;

   // expected control fields of one output beat
   typedef struct packed {
      logic sop;
      logic eop;
      logic err;
      stream_pkg::empty_t empty;
      lane_pkg::num_valid_t n;
   } beat_t;

   logic clk;
   logic arst;
   lane_pkg::num_valid_t in_num_valid;
   logic [LANES-1:0] in_sop;
   lane_pkg::eop_code_t [LANES-1:0] in_eop;
   lane_pkg::word_t [LANES-1:0] in_data;
   lane_pkg::word_t [LANES-1:0] out_data;
   logic out_valid;
   logic out_sop;
   logic out_eop;
   stream_pkg::empty_t out_empty;
   logic out_error;
   logic overflow;

   lane_word_t tx_q [$];
   beat_t exp_beats [$];
   lane_pkg::word_t exp_words [$];

   int seed;
   int errors;
   int tests_done;
   int beats_checked;
   int words_in;
   int words_out;
   bit timed_out;
   bit check_on;

   regroup_top #(
      .ADDR_WIDTH (6),
      .EOP_DEPTH  (8)
   ) uut (
      .clk          (clk),
      .arst         (arst),
      .in_num_valid (in_num_valid),
      .in_sop       (in_sop),
      .in_eop       (in_eop),
      .in_data      (in_data),
      .out_data     (out_data),
      .out_valid    (out_valid),
      .out_sop      (out_sop),
      .out_eop      (out_eop),
      .out_empty    (out_empty),
      .out_error    (out_error),
      .overflow     (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // reference model and compare
   //////////////////////////////////////////////////

   // beat idx of a packet of n_words words, tail = bytes in last word (1..8)
   function automatic beat_t model_beat(input int n_words, input int tail,
                                        input bit err, input int idx);
      beat_t b;
      int nb;
      int n;
      nb = (n_words + 3) / 4;
      n = (idx == nb - 1) ? n_words - 4 * idx : 4;
      b.sop = (idx == 0);
      b.eop = (idx == nb - 1);
      b.err = b.eop && err;
      b.n = lane_pkg::num_valid_t'(n);
      if (b.eop && !err) begin
         b.empty = stream_pkg::empty_t'((4 - n) * 8 + (8 - tail));
      end else begin
         b.empty = '0;
      end
      return b;
   endfunction

   task automatic compare(input string name, input logic [63:0] got,
                          input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   always @(posedge clk) begin : monitor_beats
      beat_t exp_b;
      lane_pkg::word_t w;
      if (!arst && out_valid && check_on) begin
         if (exp_beats.size() == 0) begin
            $display("unexpected output beat at %0t", $time);
            errors++;
         end else begin
            exp_b = exp_beats.pop_front();
            compare("out_sop", 64'(out_sop), 64'(exp_b.sop));
            compare("out_eop", 64'(out_eop), 64'(exp_b.eop));
            compare("out_error", 64'(out_error), 64'(exp_b.err));
            compare("out_empty", 64'(out_empty), 64'(exp_b.empty));
            for (int l = 0; l < int'(exp_b.n); l++) begin
               w = exp_words.pop_front();
               compare($sformatf("out_data[%0d]", l), out_data[l], w);
            end
            beats_checked++;
            words_out <= words_out + int'(exp_b.n);
         end
      end
   end

   //////////////////////////////////////////////////
   // packet generator and drivers
   //////////////////////////////////////////////////

   task automatic queue_packet(input int n_bytes, input bit err);
      lane_word_t lw;
      int n_words;
      int tail;
      n_words = (n_bytes + 7) / 8;
      tail = n_bytes - 8 * (n_words - 1);
      for (int i = 0; i < n_words; i++) begin
         lw.data = {$random(seed), $random(seed)};
         lw.sop = (i == 0);
         lw.eop = '0;
         if (i == n_words - 1) begin
            lw.eop = err ? lane_pkg::eop_code_t'(4'b0001) : {1'b1, 3'(tail % 8)};
         end
         tx_q.push_back(lw);
         exp_words.push_back(lw.data);
      end
      for (int b = 0; b < (n_words + 3) / 4; b++) begin
         exp_beats.push_back(model_beat(n_words, tail, err, b));
      end
   endtask

   // lanes above the count stay zero
   task automatic drive_cycle(input int n);
      logic [LANES-1:0] sop;
      lane_pkg::eop_code_t [LANES-1:0] eop;
      lane_pkg::word_t [LANES-1:0] data;
      lane_word_t lw;
      int take;
      take = (n < tx_q.size()) ? n : tx_q.size();
      sop = '0;
      eop = '0;
      data = '0;
      for (int l = 0; l < take; l++) begin
         lw = tx_q.pop_front();
         sop[l] = lw.sop;
         eop[l] = lw.eop;
         data[l] = lw.data;
      end
      in_num_valid <= lane_pkg::num_valid_t'(take);
      in_sop <= sop;
      in_eop <= eop;
      in_data <= data;
      words_in += take;
   endtask

   task automatic drive_words(input bit sparse);
      int n;
      int cyc;
      cyc = 0;
      while (tx_q.size() != 0 && cyc < 2000) begin
         @(posedge clk);
         n = sparse ? int'($unsigned($random(seed)) % 5) : LANES;
         drive_cycle(n);
         cyc++;
      end
      @(posedge clk);
      drive_cycle(0);
      if (tx_q.size() != 0) begin
         $display("timeout: %0d input words were never sent", tx_q.size());
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic wait_drain(input int limit);
      int cyc;
      cyc = 0;
      while (exp_beats.size() != 0 && cyc < limit) begin
         @(posedge clk);
         cyc++;
      end
      if (exp_beats.size() != 0) begin
         $display("timeout: %0d output beats never arrived", exp_beats.size());
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      tests_done++;
      $display("test %0d %s: done, %0d errors", tests_done, name, errors - err_before);
   endtask

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////

   task automatic check_idle();
      int e0;
      e0 = errors;
      repeat (6) begin
         @(posedge clk);
         compare("out_valid", 64'(out_valid), 64'(0));
         compare("out_sop", 64'(out_sop), 64'(0));
         compare("out_eop", 64'(out_eop), 64'(0));
         compare("out_error", 64'(out_error), 64'(0));
         compare("overflow", 64'(overflow), 64'(0));
      end
      end_test("idle after reset", e0);
   endtask

   task automatic run_packets(input string name, input int count, input bit sparse,
                              input bit fixed_lengths, input bit with_errors);
      int e0;
      int n_bytes;
      e0 = errors;
      for (int p = 0; p < count; p++) begin
         if (fixed_lengths) begin
            // 4, 8 and 5 words
            n_bytes = (p % 3 == 0) ? 32 : ((p % 3 == 1) ? 64 : 40);
         end else begin
            n_bytes = 25 + int'($unsigned($random(seed)) % 276);
         end
         queue_packet(n_bytes, with_errors && (p % 2 == 0));
      end
      drive_words(sparse);
      if (!timed_out) begin
         wait_drain(400);
      end
      end_test(name, e0);
   endtask

   // nine-word packets read back as 4, 4, 1 so the buffer fills up
   task automatic test_overflow();
      int e0;
      int cyc;
      bit seen;
      bit overrun;
      e0 = errors;
      cyc = 0;
      seen = 1'b0;
      overrun = 1'b0;
      while (!seen && !overrun && cyc < 400) begin
         if (tx_q.size() < LANES) begin
            queue_packet(72, 1'b0);
         end
         @(posedge clk);
         if (overflow) begin
            seen = 1'b1;
         end else if (words_in - words_out > 80) begin
            // buffer plus words still in the pipeline
            overrun = 1'b1;
         end else begin
            drive_cycle(LANES);
         end
         cyc++;
      end
      drive_cycle(0);
      check_on <= 1'b0;
      if (overrun) begin
         $display("more than 80 words held without overflow being raised");
         errors++;
      end else if (!seen) begin
         $display("timeout: overflow was never raised");
         timed_out = 1'b1;
         errors++;
      end
      end_test("overflow", e0);
   endtask

   initial begin
      seed = 93545;
      errors = 0;
      tests_done = 0;
      beats_checked = 0;
      words_in = 0;
      words_out = 0;
      timed_out = 1'b0;
      check_on = 1'b1;
      in_num_valid = '0;
      in_sop = '0;
      in_eop = '0;
      in_data = '0;
      arst = 1'b1;
      repeat (4) @(posedge clk);
      arst <= 1'b0;
      check_idle();
      if (!timed_out) run_packets("full rate 4/8/5 words", 9, 1'b0, 1'b1, 1'b0);
      if (!timed_out) run_packets("random lengths", 12, 1'b0, 1'b0, 1'b0);
      if (!timed_out) run_packets("error ends", 4, 1'b0, 1'b0, 1'b1);
      if (!timed_out) run_packets("sparse input", 10, 1'b1, 1'b0, 1'b0);
      if (!timed_out) test_overflow();
      $display("tests %0d, beats checked %0d, errors %0d", tests_done, beats_checked, errors);
      if (errors == 0 && !timed_out) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
lane_pkg.sv
stream_pkg.sv
word_ram_if.sv
word_writer.sv
read_scheduler.sv
word_ram.sv
out_framer.sv
regroup_top.sv
tb_regroup.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the regrouper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_regroup -f build.f -o tb_regroup_sim

./obj_dir/tb_regroup_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
exit 0
